// ==== include/bitmanip_settings.svh ====
`ifndef BITMANIP_SETTINGS_SVH
`define BITMANIP_SETTINGS_SVH

// Operand and result width.
`define BM_DATA_W 32

// AXI4-Lite byte address width.
`define BM_ADDR_W 5

// Register map in byte offsets.
`define BM_REG_RS1    5'h00
`define BM_REG_RS2    5'h04
`define BM_REG_INSTR  5'h08
`define BM_REG_STATUS 5'h0C // Read only.
`define BM_REG_RESULT 5'h10 // Read only.

// Bit positions inside STATUS.
`define BM_STAT_DONE    0
`define BM_STAT_ILLEGAL 1
`define BM_STAT_BUSY    2

`endif

// ==== source/bitmanip_pkg.sv ====
`include "bitmanip_settings.svh"

package bitmanip_pkg;

  typedef logic [`BM_DATA_W-1:0] word_t;
  typedef logic [`BM_ADDR_W-1:0] addr_t;
  typedef logic [31:0]           instr_t;
  typedef logic [4:0]            shamt_t; // Shift amount or bit index.

  // Immediate forms reuse the register operation.
  typedef enum logic [4:0] {
    OP_NONE,
    OP_SH1ADD,
    OP_SH2ADD,
    OP_SH3ADD,
    OP_ANDN,
    OP_ORN,
    OP_XNOR,
    OP_CLZ,
    OP_CTZ,
    OP_CPOP,
    OP_MAX,
    OP_MAXU,
    OP_MIN,
    OP_MINU,
    OP_ORCB,
    OP_REV8,
    OP_ROL,
    OP_ROR,
    OP_SEXTB,
    OP_SEXTH,
    OP_ZEXTH,
    OP_BCLR,
    OP_BEXT,
    OP_BINV,
    OP_BSET
  } bit_op_t;

  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== source/bit_exec_if.sv ====
// Launch and completion handshake between the register block and execute stage.
interface bit_exec_if import bitmanip_pkg::*; ();

  logic   start; // One-cycle launch pulse.
  word_t  rs1;
  word_t  rs2;
  instr_t instr;

  word_t  result;
  logic   done;  // One cycle after start.
  logic   illegal;

  modport regs (
    output start,
    output rs1,
    output rs2,
    output instr,
    input  result,
    input  done,
    input  illegal
  );

  modport exec (
    input  start,
    input  rs1,
    input  rs2,
    input  instr,
    output result,
    output done,
    output illegal
  );

endinterface

// ==== source/bit_decoder.sv ====
module bit_decoder import bitmanip_pkg::*; (
  input  instr_t  instr,
  output bit_op_t op,
  output word_t   imm,
  output logic    use_imm,
  output logic    illegal
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  shamt_t     rs2_f; // rs2 field, or shamt in OP-IMM.

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs2_f  = instr[24:20];

  assign imm     = word_t'(rs2_f);
  assign illegal = (op == OP_NONE);

  always_comb begin
    op      = OP_NONE;
    use_imm = 1'b0;
    if (opcode == OPC_OP) begin
      case ({funct7, funct3})
        {7'b0010000, 3'b010}: op = OP_SH1ADD;
        {7'b0010000, 3'b100}: op = OP_SH2ADD;
        {7'b0010000, 3'b110}: op = OP_SH3ADD;
        {7'b0100000, 3'b111}: op = OP_ANDN;
        {7'b0100000, 3'b110}: op = OP_ORN;
        {7'b0100000, 3'b100}: op = OP_XNOR;
        {7'b0000101, 3'b110}: op = OP_MAX;
        {7'b0000101, 3'b111}: op = OP_MAXU;
        {7'b0000101, 3'b100}: op = OP_MIN;
        {7'b0000101, 3'b101}: op = OP_MINU;
        {7'b0110000, 3'b001}: op = OP_ROL;
        {7'b0110000, 3'b101}: op = OP_ROR;
        {7'b0100100, 3'b001}: op = OP_BCLR;
        {7'b0100100, 3'b101}: op = OP_BEXT;
        {7'b0110100, 3'b001}: op = OP_BINV;
        {7'b0010100, 3'b001}: op = OP_BSET;
        {7'b0000100, 3'b100}: op = (rs2_f == 5'd0) ? OP_ZEXTH : OP_NONE; // RV32 zext.h.
        default: op = OP_NONE;
      endcase
    end else if (opcode == OPC_OP_IMM) begin
      case ({funct7, funct3})
        {7'b0110000, 3'b001}: begin
          // Unary group selected by the rs2 field.
          case (rs2_f)
            5'd0:    op = OP_CLZ;
            5'd1:    op = OP_CTZ;
            5'd2:    op = OP_CPOP;
            5'd4:    op = OP_SEXTB;
            5'd5:    op = OP_SEXTH;
            default: op = OP_NONE;
          endcase
        end
        {7'b0010100, 3'b101}: op = (rs2_f == 5'd7) ? OP_ORCB : OP_NONE;
        {7'b0110100, 3'b101}: op = (rs2_f == 5'd24) ? OP_REV8 : OP_NONE;
        {7'b0110000, 3'b101}: op = OP_ROR;  // rori
        {7'b0100100, 3'b001}: op = OP_BCLR; // bclri
        {7'b0100100, 3'b101}: op = OP_BEXT; // bexti
        {7'b0110100, 3'b001}: op = OP_BINV; // binvi
        {7'b0010100, 3'b001}: op = OP_BSET; // bseti
        default: op = OP_NONE;
      endcase
      use_imm = (op == OP_ROR) || (op == OP_BCLR) || (op == OP_BEXT) ||
                (op == OP_BINV) || (op == OP_BSET);
    end
  end

endmodule

// ==== source/bit_alu.sv ====
module bit_alu import bitmanip_pkg::*; (
  input  bit_op_t op,
  input  word_t   rdata1,
  input  word_t   rdata2,
  output word_t   result
);

  localparam int W = $bits(word_t);

  shamt_t index; // Rotate amount or bit position.
  word_t  bit_mask;

  assign index    = rdata2[4:0];
  assign bit_mask = word_t'(1) << index;

  function automatic word_t count_lz(word_t a);
    word_t cnt;
    logic  hit;
    cnt = '0;
    hit = 1'b0;
    for (int i = W - 1; i >= 0; i--) begin
      if (a[i]) begin
        hit = 1'b1;
      end else if (!hit) begin
        cnt = cnt + 1'b1;
      end
    end
    return cnt;
  endfunction

  function automatic word_t count_tz(word_t a);
    word_t cnt;
    logic  hit;
    cnt = '0;
    hit = 1'b0;
    for (int i = 0; i < W; i++) begin
      if (a[i]) begin
        hit = 1'b1;
      end else if (!hit) begin
        cnt = cnt + 1'b1;
      end
    end
    return cnt;
  endfunction

  function automatic word_t count_pop(word_t a);
    word_t cnt;
    cnt = '0;
    for (int i = 0; i < W; i++) begin
      cnt = cnt + word_t'(a[i]);
    end
    return cnt;
  endfunction

  // Byte-wise OR reduce to 00 or FF per byte.
  function automatic word_t or_combine(word_t a);
    word_t res;
    for (int b = 0; b < W / 8; b++) begin
      res[8*b +: 8] = (|a[8*b +: 8]) ? 8'hFF : 8'h00;
    end
    return res;
  endfunction

  function automatic word_t byte_rev(word_t a);
    word_t res;
    for (int b = 0; b < W / 8; b++) begin
      res[8*b +: 8] = a[8*(W/8-1-b) +: 8];
    end
    return res;
  endfunction

  function automatic word_t rotate(word_t a, shamt_t s, logic left);
    logic [2*W-1:0] dbl;
    dbl = {a, a};
    if (left) begin
      dbl = dbl << s;
      return dbl[2*W-1:W];
    end
    dbl = dbl >> s;
    return dbl[W-1:0];
  endfunction

  always_comb begin
    case (op)
      OP_SH1ADD: result = (rdata1 << 1) + rdata2;
      OP_SH2ADD: result = (rdata1 << 2) + rdata2;
      OP_SH3ADD: result = (rdata1 << 3) + rdata2;
      OP_ANDN:   result = rdata1 & ~rdata2;
      OP_ORN:    result = rdata1 | ~rdata2;
      OP_XNOR:   result = ~(rdata1 ^ rdata2);
      OP_CLZ:    result = count_lz(rdata1);  // 32 for zero input.
      OP_CTZ:    result = count_tz(rdata1);
      OP_CPOP:   result = count_pop(rdata1);
      OP_MAX:    result = ($signed(rdata1) > $signed(rdata2)) ? rdata1 : rdata2;
      OP_MAXU:   result = (rdata1 > rdata2) ? rdata1 : rdata2;
      OP_MIN:    result = ($signed(rdata1) < $signed(rdata2)) ? rdata1 : rdata2;
      OP_MINU:   result = (rdata1 < rdata2) ? rdata1 : rdata2;
      OP_ORCB:   result = or_combine(rdata1);
      OP_REV8:   result = byte_rev(rdata1);
      OP_ROL:    result = rotate(rdata1, index, 1'b1);
      OP_ROR:    result = rotate(rdata1, index, 1'b0);
      OP_SEXTB:  result = {{(W-8){rdata1[7]}}, rdata1[7:0]};
      OP_SEXTH:  result = {{(W-16){rdata1[15]}}, rdata1[15:0]};
      OP_ZEXTH:  result = {{(W-16){1'b0}}, rdata1[15:0]};
      OP_BCLR:   result = rdata1 & ~bit_mask;
      OP_BEXT:   result = word_t'(rdata1[index]);
      OP_BINV:   result = rdata1 ^ bit_mask;
      OP_BSET:   result = rdata1 | bit_mask;
      default:   result = '0;
    endcase
  end

endmodule

// ==== source/bit_exec.sv ====
module bit_exec import bitmanip_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  bit_exec_if.exec exec
);

  bit_op_t op;
  word_t   imm;
  word_t   op2;
  word_t   alu_result;
  logic    use_imm;
  logic    dec_illegal;

  word_t   result_q;
  logic    done_q;
  logic    illegal_q;

  bit_decoder u_decoder (
    .instr   (exec.instr),
    .op      (op),
    .imm     (imm),
    .use_imm (use_imm),
    .illegal (dec_illegal)
  );

  assign op2 = use_imm ? imm : exec.rs2; // shamt replaces rs2 for immediate forms.

  bit_alu u_alu (
    .op     (op),
    .rdata1 (exec.rs1),
    .rdata2 (op2),
    .result (alu_result)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
      result_q  <= '0;
    end else begin
      done_q <= exec.start;
      if (exec.start) begin
        illegal_q <= dec_illegal;
        result_q  <= dec_illegal ? '0 : alu_result;
      end
    end
  end

  assign exec.result  = result_q;
  assign exec.done    = done_q;
  assign exec.illegal = illegal_q;

endmodule

// ==== source/axil_bitmanip_regs.sv ====
`include "bitmanip_settings.svh"

module axil_bitmanip_regs import bitmanip_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      awvalid,
  output logic      awready,
  input  addr_t     awaddr,
  input  logic      wvalid,
  output logic      wready,
  input  word_t     wdata,
  output logic      bvalid,
  input  logic      bready,
  output axi_resp_t bresp,
  input  logic      arvalid,
  output logic      arready,
  input  addr_t     araddr,
  output logic      rvalid,
  input  logic      rready,
  output word_t     rdata,
  output axi_resp_t rresp,
  bit_exec_if.regs  exec
);

  word_t  rs1_q;
  word_t  rs2_q;
  instr_t instr_q;
  word_t  result_q;
  logic   start_q;
  logic   done_q;
  logic   illegal_q;
  logic   busy_q;

  logic   wr_fire;
  logic   wr_ok;
  logic   wr_instr;
  logic   rd_fire;
  logic   rd_ok;
  word_t  rd_word;
  word_t  status;

  // AW and W are taken together and never while a response or an operation is pending.
  assign awready = awvalid && wvalid && !bvalid && !busy_q;
  assign wready  = awready;
  assign wr_fire = awvalid && awready && wvalid && wready;

  assign wr_ok    = (awaddr == `BM_REG_RS1) || (awaddr == `BM_REG_RS2) ||
                    (awaddr == `BM_REG_INSTR);
  assign wr_instr = wr_fire && (awaddr == `BM_REG_INSTR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rs1_q   <= '0;
      rs2_q   <= '0;
      instr_q <= '0;
      start_q <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= RESP_OKAY;
    end else begin
      start_q <= wr_instr; // Launch in the cycle after the write.
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        case (awaddr)
          `BM_REG_RS1:   rs1_q   <= wdata;
          `BM_REG_RS2:   rs2_q   <= wdata;
          `BM_REG_INSTR: instr_q <= instr_t'(wdata);
          default:       ;
        endcase
      end
    end
  end

  // Operation status.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
      result_q  <= '0;
    end else if (wr_instr) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
    end else if (exec.done) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b1;
      illegal_q <= exec.illegal;
      result_q  <= exec.result;
    end
  end

  always_comb begin
    status                   = '0;
    status[`BM_STAT_DONE]    = done_q;
    status[`BM_STAT_ILLEGAL] = illegal_q;
    status[`BM_STAT_BUSY]    = busy_q;
  end

  always_comb begin
    rd_ok = 1'b1;
    case (araddr)
      `BM_REG_RS1:    rd_word = rs1_q;
      `BM_REG_RS2:    rd_word = rs2_q;
      `BM_REG_INSTR:  rd_word = word_t'(instr_q);
      `BM_REG_STATUS: rd_word = status;
      `BM_REG_RESULT: rd_word = result_q;
      default: begin
        rd_word = '0; // Unmapped.
        rd_ok   = 1'b0;
      end
    endcase
  end

  assign arready = rst_n && !rvalid;
  assign rd_fire = arvalid && arready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
      rdata  <= rd_word;
      rresp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

  assign exec.start = start_q;
  assign exec.rs1   = rs1_q;
  assign exec.rs2   = rs2_q;
  assign exec.instr = instr_q;

endmodule

// ==== source/bitmanip_top.sv ====
module bitmanip_top import bitmanip_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      awvalid,
  output logic      awready,
  input  addr_t     awaddr,
  input  logic      wvalid,
  output logic      wready,
  input  word_t     wdata,
  output logic      bvalid,
  input  logic      bready,
  output axi_resp_t bresp,
  input  logic      arvalid,
  output logic      arready,
  input  addr_t     araddr,
  output logic      rvalid,
  input  logic      rready,
  output word_t     rdata,
  output axi_resp_t rresp
);

  bit_exec_if exec_bus ();

  axil_bitmanip_regs u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .exec    (exec_bus)
  );

  // One operation in flight at a time.
  bit_exec u_exec (
    .clk   (clk),
    .rst_n (rst_n),
    .exec  (exec_bus)
  );

endmodule

// ==== testbench/bitmanip_assertions.sv ====
module bitmanip_assertions import bitmanip_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      awready,
  input logic      wready,
  input logic      bvalid,
  input logic      bready,
  input axi_resp_t bresp,
  input logic      rvalid,
  input logic      rready,
  input word_t     rdata,
  input axi_resp_t rresp,
  input logic      done,
  input logic      busy
);
  timeunit 1ns;
  timeprecision 1ps;

  // A stalled response holds its valid and payload.
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("B response dropped or changed before bready");

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("R response dropped or changed before rready");

  // Busy spans the launch and the execute cycle, then done takes over.
  done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> !done ##1 (busy && !done) ##1 (done && !busy))
    else $error("STATUS done and busy overlap or done came at the wrong cycle");

  reset_idle: assert property (@(posedge clk)
    $rose(rst_n) |-> !awready && !wready && !bvalid && !rvalid && !done && !busy)
    else $error("Outputs not idle just after reset");

endmodule

bind bitmanip_top bitmanip_assertions u_assertions (
  .clk     (clk),
  .rst_n   (rst_n),
  .awready (awready),
  .wready  (wready),
  .bvalid  (bvalid),
  .bready  (bready),
  .bresp   (bresp),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata),
  .rresp   (rresp),
  .done    (u_regs.done_q),
  .busy    (u_regs.busy_q)
);

// ==== testbench/bitmanip_tb.sv ====
`include "bitmanip_settings.svh"

module bitmanip_tb import bitmanip_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    WAIT_LIMIT = 50; // Cycles per handshake wait.
  localparam int    POLL_LIMIT = 20; // STATUS reads per operation.
  localparam word_t ST_DONE    = 32'h1;
  localparam word_t ST_ILLEGAL = 32'h2;

  logic      clk;
  logic      rst_n;
  logic      awvalid;
  logic      awready;
  addr_t     awaddr;
  logic      wvalid;
  logic      wready;
  word_t     wdata;
  logic      bvalid;
  logic      bready;
  axi_resp_t bresp;
  logic      arvalid;
  logic      arready;
  addr_t     araddr;
  logic      rvalid;
  logic      rready;
  word_t     rdata;
  axi_resp_t rresp;

  int seed = 32'h46bd_19d7;

  bitmanip_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Cycles that bready stays low once bvalid is seen.
  task automatic axil_write(input addr_t addr, input word_t data, input int hold,
                            output axi_resp_t resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!awready) begin
      n++;
      if (n > WAIT_LIMIT) stop_with_error("Timeout: write address and data never accepted.");
      @(negedge clk);
    end
    check_value("wready", word_t'(wready), 32'h1);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!bvalid) begin
      n++;
      if (n > WAIT_LIMIT) stop_with_error("Timeout: no write response arrived.");
      @(negedge clk);
    end
    resp = bresp;
    repeat (hold) begin
      @(negedge clk);
      check_value("bvalid while stalled", word_t'(bvalid), 32'h1);
      check_value("bresp while stalled", word_t'(bresp), word_t'(resp));
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axil_read(input addr_t addr, output word_t data, input int hold,
                           output axi_resp_t resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!arready) begin
      n++;
      if (n > WAIT_LIMIT) stop_with_error("Timeout: read address never accepted.");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    n = 0;
    @(negedge clk);
    while (!rvalid) begin
      n++;
      if (n > WAIT_LIMIT) stop_with_error("Timeout: no read data arrived.");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    repeat (hold) begin
      @(negedge clk);
      check_value("rvalid while stalled", word_t'(rvalid), 32'h1);
      check_value("rdata while stalled", rdata, data);
      check_value("rresp while stalled", word_t'(rresp), word_t'(resp));
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // rs1 is x1 and rd is x3. f5 is the rs2 field or the shamt.
  function automatic instr_t encode(input logic imm_form, input logic [6:0] f7,
                                    input logic [4:0] f5, input logic [2:0] f3);
    return {f7, f5, 5'd1, f3, 5'd3, imm_form ? 7'b0010011 : 7'b0110011};
  endfunction

  function automatic word_t ref_result(input bit_op_t op, input word_t a, input word_t b);
    word_t res;
    word_t v;
    int    cnt;
    int    s;
    s   = int'(b[4:0]);
    res = '0;
    v   = a;
    cnt = 0;
    case (op)
      OP_SH1ADD: res = (a << 1) + b;
      OP_SH2ADD: res = (a << 2) + b;
      OP_SH3ADD: res = (a << 3) + b;
      OP_ANDN:   res = a & ~b;
      OP_ORN:    res = a | ~b;
      OP_XNOR:   res = ~(a ^ b);
      OP_CLZ: begin
        while (cnt < 32 && !v[31]) begin
          v = v << 1;
          cnt++;
        end
        res = word_t'(cnt);
      end
      OP_CTZ: begin
        while (cnt < 32 && !v[0]) begin
          v = v >> 1;
          cnt++;
        end
        res = word_t'(cnt);
      end
      OP_CPOP: begin
        repeat (32) begin
          if (v[0]) cnt++;
          v = v >> 1;
        end
        res = word_t'(cnt);
      end
      OP_MAX:  res = ($signed(a) >= $signed(b)) ? a : b;
      OP_MAXU: res = (a >= b) ? a : b;
      OP_MIN:  res = ($signed(a) <= $signed(b)) ? a : b;
      OP_MINU: res = (a <= b) ? a : b;
      OP_ORCB: begin
        for (int k = 0; k < 4; k++) begin
          if (((a >> (8 * k)) & 32'hff) != 32'h0) res = res | (32'hff << (8 * k));
        end
      end
      OP_REV8:  res = {a[7:0], a[15:8], a[23:16], a[31:24]};
      OP_ROL:   res = (a << s) | (a >> (32 - s)); // Shift by 32 gives 0.
      OP_ROR:   res = (a >> s) | (a << (32 - s));
      OP_SEXTB: res = {{24{a[7]}}, a[7:0]};
      OP_SEXTH: res = {{16{a[15]}}, a[15:0]};
      OP_ZEXTH: res = {16'h0, a[15:0]};
      OP_BCLR:  res = a & ~(32'h1 << s);
      OP_BEXT:  res = (a >> s) & 32'h1;
      OP_BINV:  res = a ^ (32'h1 << s);
      OP_BSET:  res = a | (32'h1 << s);
      default:  res = '0;
    endcase
    return res;
  endfunction

  task automatic run_op(input word_t a, input word_t b, input instr_t instr,
                        output word_t res, output word_t status);
    axi_resp_t resp;
    int        n;
    axil_write(`BM_REG_RS1, a, 0, resp);
    check_value("bresp RS1", word_t'(resp), word_t'(RESP_OKAY));
    axil_write(`BM_REG_RS2, b, 0, resp);
    check_value("bresp RS2", word_t'(resp), word_t'(RESP_OKAY));
    axil_write(`BM_REG_INSTR, instr, 0, resp);
    check_value("bresp INSTR", word_t'(resp), word_t'(RESP_OKAY));
    status = '0;
    n = 0;
    while (!status[`BM_STAT_DONE]) begin
      n++;
      if (n > POLL_LIMIT) stop_with_error("Timeout: STATUS never showed done.");
      axil_read(`BM_REG_STATUS, status, 0, resp);
    end
    axil_read(`BM_REG_RESULT, res, 0, resp);
    check_value("rresp RESULT", word_t'(resp), word_t'(RESP_OKAY));
  endtask

  // op2 is the shamt for immediate forms and rs2 otherwise.
  task automatic verify_op(input string name, input instr_t instr, input bit_op_t op,
                           input word_t a, input word_t rs2, input word_t op2);
    word_t res;
    word_t status;
    run_op(a, rs2, instr, res, status);
    check_value({name, " STATUS"}, status, ST_DONE);
    check_value({name, " RESULT"}, res, ref_result(op, a, op2));
  endtask

  task automatic reg_reg_case(input string name, input logic [6:0] f7, input logic [2:0] f3,
                              input bit_op_t op);
    instr_t instr;
    word_t  a;
    word_t  b;
    instr = encode(1'b0, f7, 5'd2, f3);
    // Signed and unsigned order disagree on these pairs.
    verify_op(name, instr, op, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000);
    verify_op(name, instr, op, 32'h7fff_ffff, 32'hffff_ffff, 32'hffff_ffff);
    verify_op(name, instr, op, 32'hffff_ffff, 32'h7fff_ffff, 32'h7fff_ffff);
    repeat (3) begin
      a = $random(seed);
      b = $random(seed);
      verify_op(name, instr, op, a, b, b);
    end
  endtask

  task automatic unary_case(input string name, input logic imm_form, input logic [6:0] f7,
                            input logic [4:0] f5, input logic [2:0] f3, input bit_op_t op);
    instr_t instr;
    word_t  a;
    word_t  b;
    instr = encode(imm_form, f7, f5, f3);
    b     = $random(seed);
    verify_op(name, instr, op, 32'h0000_0000, b, b);
    verify_op(name, instr, op, 32'hffff_ffff, b, b);
    verify_op(name, instr, op, 32'h0000_8080, b, b); // Sign bits of byte and half.
    repeat (3) begin
      a = $random(seed);
      verify_op(name, instr, op, a, b, b);
    end
  endtask

  task automatic imm_case(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input bit_op_t op);
    shamt_t sh;
    word_t  a;
    word_t  b;
    for (int k = 0; k < 4; k++) begin
      if (k == 0) sh = 5'd0;
      else if (k == 1) sh = 5'd31;
      else sh = shamt_t'($random(seed));
      a = $random(seed);
      b = $random(seed); // RS2 holds noise.
      verify_op(name, encode(1'b1, f7, sh, f3), op, a, b, word_t'(sh));
    end
  endtask

  task automatic register_readback();
    word_t     a;
    word_t     b;
    word_t     got;
    axi_resp_t resp;
    axil_read(`BM_REG_STATUS, got, 0, resp);
    check_value("STATUS after reset", got, '0);
    check_value("rresp STATUS", word_t'(resp), word_t'(RESP_OKAY));
    a = $random(seed);
    b = $random(seed);
    axil_write(`BM_REG_RS1, a, 0, resp);
    check_value("bresp RS1", word_t'(resp), word_t'(RESP_OKAY));
    axil_write(`BM_REG_RS2, b, 0, resp);
    check_value("bresp RS2", word_t'(resp), word_t'(RESP_OKAY));
    axil_read(`BM_REG_RS1, got, 0, resp);
    check_value("RS1 readback", got, a);
    axil_read(`BM_REG_RS2, got, 0, resp);
    check_value("RS2 readback", got, b);
  endtask

  task automatic reg_reg_ops();
    reg_reg_case("sh1add", 7'b0010000, 3'b010, OP_SH1ADD);
    reg_reg_case("sh2add", 7'b0010000, 3'b100, OP_SH2ADD);
    reg_reg_case("sh3add", 7'b0010000, 3'b110, OP_SH3ADD);
    reg_reg_case("andn", 7'b0100000, 3'b111, OP_ANDN);
    reg_reg_case("orn", 7'b0100000, 3'b110, OP_ORN);
    reg_reg_case("xnor", 7'b0100000, 3'b100, OP_XNOR);
    reg_reg_case("min", 7'b0000101, 3'b100, OP_MIN);
    reg_reg_case("minu", 7'b0000101, 3'b101, OP_MINU);
    reg_reg_case("max", 7'b0000101, 3'b110, OP_MAX);
    reg_reg_case("maxu", 7'b0000101, 3'b111, OP_MAXU);
    reg_reg_case("rol", 7'b0110000, 3'b001, OP_ROL);
    reg_reg_case("ror", 7'b0110000, 3'b101, OP_ROR);
    reg_reg_case("bclr", 7'b0100100, 3'b001, OP_BCLR);
    reg_reg_case("bext", 7'b0100100, 3'b101, OP_BEXT);
    reg_reg_case("binv", 7'b0110100, 3'b001, OP_BINV);
    reg_reg_case("bset", 7'b0010100, 3'b001, OP_BSET);
  endtask

  task automatic unary_ops();
    unary_case("clz", 1'b1, 7'b0110000, 5'd0, 3'b001, OP_CLZ);
    unary_case("ctz", 1'b1, 7'b0110000, 5'd1, 3'b001, OP_CTZ);
    unary_case("cpop", 1'b1, 7'b0110000, 5'd2, 3'b001, OP_CPOP);
    unary_case("orc.b", 1'b1, 7'b0010100, 5'd7, 3'b101, OP_ORCB);
    unary_case("rev8", 1'b1, 7'b0110100, 5'd24, 3'b101, OP_REV8);
    unary_case("sext.b", 1'b1, 7'b0110000, 5'd4, 3'b001, OP_SEXTB);
    unary_case("sext.h", 1'b1, 7'b0110000, 5'd5, 3'b001, OP_SEXTH);
    unary_case("zext.h", 1'b0, 7'b0000100, 5'd0, 3'b100, OP_ZEXTH); // Encoded in OP.
  endtask

  task automatic immediate_forms();
    imm_case("rori", 7'b0110000, 3'b101, OP_ROR);
    imm_case("bclri", 7'b0100100, 3'b001, OP_BCLR);
    imm_case("bexti", 7'b0100100, 3'b101, OP_BEXT);
    imm_case("binvi", 7'b0110100, 3'b001, OP_BINV);
    imm_case("bseti", 7'b0010100, 3'b001, OP_BSET);
  endtask

  task automatic illegal_instr();
    word_t res;
    word_t status;
    // Leaves a nonzero RESULT behind.
    verify_op("andn", encode(1'b0, 7'b0100000, 5'd2, 3'b111), OP_ANDN,
              32'hffff_ffff, 32'h0, 32'h0);
    run_op($random(seed), $random(seed), encode(1'b0, 7'b0000000, 5'd2, 3'b000), res, status);
    check_value("add STATUS", status, ST_DONE | ST_ILLEGAL);
    check_value("add RESULT", res, '0);
    // OP-IMM unary group with an unused rs2 field.
    run_op(32'h1234_5678, '0, encode(1'b1, 7'b0110000, 5'd3, 3'b001), res, status);
    check_value("unary rs2=3 STATUS", status, ST_DONE | ST_ILLEGAL);
    check_value("unary rs2=3 RESULT", res, '0);
    verify_op("orn", encode(1'b0, 7'b0100000, 5'd2, 3'b110), OP_ORN,
              32'h0f0f_0000, 32'hffff_0f0f, 32'hffff_0f0f);
  endtask

  task automatic bus_errors();
    word_t     got;
    word_t     keep;
    axi_resp_t resp;
    axil_write(5'h14, 32'h5a5a_0001, 0, resp);
    check_value("bresp unmapped", word_t'(resp), word_t'(RESP_SLVERR));
    axil_read(5'h14, got, 0, resp);
    check_value("rresp unmapped", word_t'(resp), word_t'(RESP_SLVERR));
    check_value("rdata unmapped", got, '0);
    axil_read(`BM_REG_RESULT, keep, 0, resp);
    axil_write(`BM_REG_RESULT, ~keep, 3, resp);
    check_value("bresp RESULT write", word_t'(resp), word_t'(RESP_SLVERR));
    axil_write(`BM_REG_STATUS, 32'h7, 0, resp);
    check_value("bresp STATUS write", word_t'(resp), word_t'(RESP_SLVERR));
    axil_read(`BM_REG_RESULT, got, 0, resp);
    check_value("RESULT after write", got, keep);
    axil_read(`BM_REG_STATUS, got, 0, resp);
    check_value("STATUS after write", got, ST_DONE);
    axil_read(5'h1C, got, 4, resp);
    check_value("rresp unmapped stalled", word_t'(resp), word_t'(RESP_SLVERR));
    check_value("rdata unmapped stalled", got, '0);
    axil_read(`BM_REG_RS1, got, 4, resp);
    check_value("rresp RS1 stalled", word_t'(resp), word_t'(RESP_OKAY));
  endtask

  initial begin
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    register_readback();
    reg_reg_ops();
    unary_ops();
    immediate_forms();
    illegal_instr();
    bus_errors();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
source/bitmanip_pkg.sv
source/bit_exec_if.sv
source/bit_decoder.sv
source/bit_alu.sv
source/bit_exec.sv
source/axil_bitmanip_regs.sv
source/bitmanip_top.sv
testbench/bitmanip_assertions.sv
testbench/bitmanip_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the bit-manipulation coprocessor testbench with Verilator and runs it.
# The simulator exits with a nonzero status when a check or an assertion fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module bitmanip_tb -f build.f -o bitmanip_sim

./obj_dir/bitmanip_sim
